/* isa_pkg.sv */
// Instruction set constants
package isa_pkg;

	//////////////////////////////////////////////////
	// Instruction word
	//////////////////////////////////////////////////

	// One 32-bit instruction
	typedef logic [31:0] insn_t;

	// Byte size of one instruction, used as the PC step
	localparam logic [31:0] INSN_BYTES = 32'd4;

	//////////////////////////////////////////////////
	// No-op encodings
	//////////////////////////////////////////////////

	// Major opcode of the no-op class
	localparam logic [5:0] NOP_OPCODE = 6'b000101;

	// Inserted on flush, delay-slot end and rfe
	localparam insn_t NOP_BYPASS = {NOP_OPCODE, 26'h041_0000};
	// Shown while memory has not answered
	localparam insn_t NOP_NOACK = {NOP_OPCODE, 26'h061_0000};

	// First fetch address out of reset
	localparam logic [31:0] RESET_VECTOR = 32'h0000_0100;

endpackage

/* fetch_bus_pkg.sv */
// Fetch bus types and constants
package fetch_bus_pkg;

	//////////////////////////////////////////////////
	// Bus types
	//////////////////////////////////////////////////

	// Byte address
	typedef logic [31:0] addr_t;
	// Fault tag returned with err
	typedef logic [3:0] tag_t;

	// Clears the byte offset of an address
	localparam addr_t ADDR_WORD_MASK = 32'hFFFF_FFFC;

	// Fault tag codes
	localparam tag_t ITAG_NONE = 4'h0;
	localparam tag_t ITAG_BE   = 4'hb;
	localparam tag_t ITAG_PE   = 4'hc;
	localparam tag_t ITAG_TE   = 4'hd;

	// Instruction memory geometry and latency
	localparam int unsigned IMEM_DEPTH = 256;
	localparam int unsigned IMEM_AW    = $clog2(IMEM_DEPTH);
	localparam int unsigned IMEM_WAIT  = 2;
	localparam int unsigned WAIT_CNT_W = $clog2(IMEM_WAIT + 1);

	typedef logic [IMEM_AW-1:0] imem_idx_t;
	typedef logic [WAIT_CNT_W-1:0] wait_cnt_t;

endpackage

/* fetch_bus_if.sv */
// Instruction fetch bus
`timescale 1ns/10ps

interface fetch_bus_if;

	// Request side
	logic                 req;
	fetch_bus_pkg::addr_t adr;

	// Response side, dat only meaningful with ack
	isa_pkg::insn_t       dat;
	logic                 ack;
	logic                 err;
	fetch_bus_pkg::tag_t  tag;

	// PC generator issues requests
	modport gen (output req, output adr, input ack, input err);

	// Memory answers them
	modport mem (input req, input adr, output dat, output ack, output err, output tag);

	// Fetch stage only watches
	modport stage (input req, input adr, input dat, input ack, input err, input tag);

endinterface

/* fetch_genpc.sv */
// Program counter generator
`timescale 1ns/10ps

module fetch_genpc (
	input  logic                 clk,
	input  logic                 rst_i,
	input  logic                 freeze_i,
	input  logic                 flushpipe_i,
	input  fetch_bus_pkg::addr_t branch_target_i,
	input  logic                 genpc_refetch_i,
	fetch_bus_if.gen             bus
);

	// Current fetch address
	fetch_bus_pkg::addr_t pc_q;
	// Request outstanding on the bus
	logic req_q;
	// PC step owed from a response taken under freeze
	logic adv_q;
	// Response to our own request
	logic resp;

	assign resp = req_q & (bus.ack | bus.err);

	// Address held stable for the whole request
	assign bus.req = req_q;
	assign bus.adr = pc_q;

	//////////////////////////////////////////////////
	// PC and request sequencing
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst_i) begin
			pc_q  <= isa_pkg::RESET_VECTOR;
			req_q <= 1'b0;
			adv_q <= 1'b0;
		end else if (flushpipe_i) begin
			// Drop whatever is pending, restart at target
			pc_q  <= branch_target_i;
			req_q <= 1'b0;
			adv_q <= 1'b0;
		end else if (resp) begin
			// Release req for one idle cycle
			req_q <= 1'b0;
			if (genpc_refetch_i) begin
				// Same address again
				adv_q <= 1'b0;
			end else if (freeze_i) begin
				// Word parked in stage, step later
				adv_q <= 1'b1;
			end else begin
				pc_q <= pc_q + isa_pkg::INSN_BYTES;
			end
		end else if (!req_q && !freeze_i) begin
			// Launch next request, first the owed step
			req_q <= 1'b1;
			if (adv_q) begin
				pc_q  <= pc_q + isa_pkg::INSN_BYTES;
				adv_q <= 1'b0;
			end
		end
	end

endmodule

/* fetch_imem.sv */
// Instruction memory with wait states
`timescale 1ns/10ps

module fetch_imem (
	input  logic                 clk,
	input  logic                 rst_i,
	input  logic                 wr_en_i,
	input  fetch_bus_pkg::addr_t wr_addr_i,
	input  isa_pkg::insn_t       wr_data_i,
	input  fetch_bus_pkg::tag_t  wr_tag_i,
	fetch_bus_if.mem             bus
);

	// Word and fault tag storage
	isa_pkg::insn_t      mem_q [fetch_bus_pkg::IMEM_DEPTH];
	fetch_bus_pkg::tag_t tags_q [fetch_bus_pkg::IMEM_DEPTH];

	fetch_bus_pkg::imem_idx_t wr_idx;
	fetch_bus_pkg::imem_idx_t rd_idx;
	fetch_bus_pkg::wait_cnt_t cnt_q;
	logic                     busy_q;
	logic                     ack_q;
	logic                     err_q;
	isa_pkg::insn_t           dat_q;
	fetch_bus_pkg::tag_t      tag_q;
	logic                     start;
	logic                     fire;

	// Word index, wraps modulo depth
	assign wr_idx = fetch_bus_pkg::imem_idx_t'(wr_addr_i >> 2);
	assign rd_idx = fetch_bus_pkg::imem_idx_t'(bus.adr >> 2);

	// New request, not the tail of the one just answered
	assign start = bus.req & ~busy_q & ~ack_q & ~err_q;
	// Last wait cycle
	assign fire = busy_q & bus.req & (cnt_q == fetch_bus_pkg::wait_cnt_t'(1));

	// Load port
	always_ff @(posedge clk) begin
		if (wr_en_i) begin
			mem_q[wr_idx]  <= wr_data_i;
			tags_q[wr_idx] <= wr_tag_i;
		end
	end

	//////////////////////////////////////////////////
	// Wait counter and response strobes
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst_i) begin
			busy_q <= 1'b0;
			cnt_q  <= '0;
			ack_q  <= 1'b0;
			err_q  <= 1'b0;
		end else begin
			// Strobes last one cycle
			ack_q <= 1'b0;
			err_q <= 1'b0;
			if (start) begin
				busy_q <= 1'b1;
				cnt_q  <= fetch_bus_pkg::wait_cnt_t'(fetch_bus_pkg::IMEM_WAIT - 1);
			end else if (busy_q && !bus.req) begin
				// Requester gave up, no answer
				busy_q <= 1'b0;
			end else if (fire) begin
				busy_q <= 1'b0;
				ack_q  <= (tags_q[rd_idx] == fetch_bus_pkg::ITAG_NONE);
				err_q  <= (tags_q[rd_idx] != fetch_bus_pkg::ITAG_NONE);
			end else if (busy_q) begin
				cnt_q <= cnt_q - fetch_bus_pkg::wait_cnt_t'(1);
			end
		end
	end

	// Read data and tag, captured with the strobe
	always_ff @(posedge clk) begin
		if (fire) begin
			dat_q <= mem_q[rd_idx];
			tag_q <= tags_q[rd_idx];
		end
	end

	assign bus.ack = ack_q;
	assign bus.err = err_q;
	assign bus.dat = dat_q;
	assign bus.tag = tag_q;

endmodule

/* fetch_stage.sv */
// Instruction fetch stage
`timescale 1ns/10ps

module fetch_stage (
	input  logic                 clk,
	input  logic                 rst_i,
	input  logic                 freeze_i,
	input  logic                 flushpipe_i,
	input  logic                 no_more_dslot_i,
	input  logic                 rfe_i,
	fetch_bus_if.stage           bus,
	output isa_pkg::insn_t       insn_o,
	output fetch_bus_pkg::addr_t pc_o,
	output logic                 stall_o,
	output logic                 saving_insn_o,
	output logic                 genpc_refetch_o,
	output logic                 except_itlbmiss_o,
	output logic                 except_immufault_o,
	output logic                 except_ibuserr_o
);

	logic                 save_insn;
	logic                 bypass;
	logic                 bypass_q;
	logic                 saved_q;
	isa_pkg::insn_t       insn_saved_q;
	fetch_bus_pkg::addr_t addr_saved_q;
	fetch_bus_pkg::addr_t adr_word;
	// Bit 0 TE, bit 1 PE, bit 2 BE
	logic [2:0]           err_live;
	logic [2:0]           err_saved_q;
	logic [2:0]           err_sel;

	assign adr_word = bus.adr & fetch_bus_pkg::ADDR_WORD_MASK;

	// Fault tag decode of the live response
	assign err_live[0] = bus.err & (bus.tag == fetch_bus_pkg::ITAG_TE);
	assign err_live[1] = bus.err & (bus.tag == fetch_bus_pkg::ITAG_PE);
	assign err_live[2] = bus.err & (bus.tag == fetch_bus_pkg::ITAG_BE);

	// Park a response that decode cannot take
	assign save_insn     = (bus.ack | bus.err) & freeze_i & ~saved_q;
	assign saving_insn_o = ~flushpipe_i & save_insn;

	// No-ops until the first request to the flush target
	assign bypass = flushpipe_i | (bypass_q & ~bus.req);

	//////////////////////////////////////////////////
	// Saved word state
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst_i) begin
			bypass_q    <= 1'b0;
			saved_q     <= 1'b0;
			err_saved_q <= '0;
		end else begin
			bypass_q <= bypass;
			if (flushpipe_i) begin
				saved_q     <= 1'b0;
				err_saved_q <= '0;
			end else if (save_insn) begin
				saved_q     <= 1'b1;
				err_saved_q <= err_live;
			end else if (!freeze_i) begin
				saved_q     <= 1'b0;
				err_saved_q <= '0;
			end
		end
	end

	// Word and its address, same priority as the flag
	always_ff @(posedge clk) begin
		if (flushpipe_i) begin
			insn_saved_q <= isa_pkg::NOP_BYPASS;
			addr_saved_q <= '0;
		end else if (save_insn) begin
			// Faulted fetch parks a no-op
			insn_saved_q <= bus.err ? isa_pkg::NOP_BYPASS : bus.dat;
			addr_saved_q <= adr_word;
		end else if (!freeze_i) begin
			insn_saved_q <= isa_pkg::NOP_BYPASS;
			addr_saved_q <= adr_word;
		end
	end

	//////////////////////////////////////////////////
	// Outputs to decode
	//////////////////////////////////////////////////

	always_comb begin
		if (no_more_dslot_i || rfe_i || bypass) begin
			insn_o = isa_pkg::NOP_BYPASS;
		end else if (saved_q) begin
			insn_o = insn_saved_q;
		end else if (bus.ack) begin
			insn_o = bus.dat;
		end else begin
			insn_o = isa_pkg::NOP_NOACK;
		end
	end

	assign pc_o            = saved_q ? addr_saved_q : adr_word;
	assign stall_o         = ~bus.ack & ~bus.err & ~saved_q;
	// Fresh ack over a parked word, fetch it again
	assign genpc_refetch_o = saved_q & bus.ack;

	// Exceptions from parked or live tags, masked at delay-slot end
	assign err_sel            = saved_q ? err_saved_q : err_live;
	assign except_itlbmiss_o  = ~no_more_dslot_i & err_sel[0];
	assign except_immufault_o = ~no_more_dslot_i & err_sel[1];
	assign except_ibuserr_o   = ~no_more_dslot_i & err_sel[2];

endmodule

/* fetch_top.sv */
// Fetch front end top level
`timescale 1ns/10ps

module fetch_top (
	input  logic                 clk,
	input  logic                 rst_i,
	input  logic                 freeze_i,
	input  logic                 flushpipe_i,
	input  fetch_bus_pkg::addr_t branch_target_i,
	input  logic                 no_more_dslot_i,
	input  logic                 rfe_i,
	// Memory load port
	input  logic                 wr_en_i,
	input  fetch_bus_pkg::addr_t wr_addr_i,
	input  isa_pkg::insn_t       wr_data_i,
	input  fetch_bus_pkg::tag_t  wr_tag_i,
	// Toward decode
	output isa_pkg::insn_t       insn_o,
	output fetch_bus_pkg::addr_t pc_o,
	output logic                 stall_o,
	output logic                 saving_insn_o,
	output logic                 genpc_refetch_o,
	output logic                 except_itlbmiss_o,
	output logic                 except_immufault_o,
	output logic                 except_ibuserr_o
);

	// Shared fetch bus
	fetch_bus_if bus_if ();

	// PC generator
	fetch_genpc u_genpc (
		.clk             (clk),
		.rst_i           (rst_i),
		.freeze_i        (freeze_i),
		.flushpipe_i     (flushpipe_i),
		.branch_target_i (branch_target_i),
		.genpc_refetch_i (genpc_refetch_o),
		.bus             (bus_if.gen)
	);

	// Instruction memory
	fetch_imem u_imem (
		.clk       (clk),
		.rst_i     (rst_i),
		.wr_en_i   (wr_en_i),
		.wr_addr_i (wr_addr_i),
		.wr_data_i (wr_data_i),
		.wr_tag_i  (wr_tag_i),
		.bus       (bus_if.mem)
	);

	// Fetch stage
	fetch_stage u_stage (
		.clk                (clk),
		.rst_i              (rst_i),
		.freeze_i           (freeze_i),
		.flushpipe_i        (flushpipe_i),
		.no_more_dslot_i    (no_more_dslot_i),
		.rfe_i              (rfe_i),
		.bus                (bus_if.stage),
		.insn_o             (insn_o),
		.pc_o               (pc_o),
		.stall_o            (stall_o),
		.saving_insn_o      (saving_insn_o),
		.genpc_refetch_o    (genpc_refetch_o),
		.except_itlbmiss_o  (except_itlbmiss_o),
		.except_immufault_o (except_immufault_o),
		.except_ibuserr_o   (except_ibuserr_o)
	);

endmodule

/* tb_clkgen.sv */
// Testbench clock and reset
`timescale 1ns/10ps

module tb_clkgen (
	input  logic hold_i,
	output logic clk_o,
	output logic rst_o
);

	localparam int PERIOD_NS    = 20;
	localparam int RESET_CYCLES = 10;

	// Free running clock
	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2) clk_o = ~clk_o;
	end

	// Reset held while memory loads, then ten more cycles
	initial begin
		rst_o = 1'b1;
		wait (hold_i == 1'b0);
		repeat (RESET_CYCLES) @(posedge clk_o);
		@(negedge clk_o);
		rst_o = 1'b0;
	end

endmodule

/* fetch_props.sv */
// Fetch front end properties
`timescale 1ns/10ps

module fetch_props (
	input logic           clk,
	input logic           rst_i,
	input logic           flushpipe_i,
	input logic           no_more_dslot_i,
	input logic           rfe_i,
	input logic           req_i,
	input logic           ack_i,
	input logic           err_i,
	input isa_pkg::insn_t insn_i,
	input logic [2:0]     exc_i
);

	// Failed assertion count, read at end of run
	int unsigned fail_cnt = 0;

	//////////////////////////////////////////////////
	// Bus protocol
	//////////////////////////////////////////////////

	// Response is a single cycle
	a_resp_pulse: assert property (@(posedge clk) disable iff (rst_i)
		(ack_i || err_i) |=> !(ack_i || err_i))
		else begin
			$error("response strobe longer than one cycle");
			fail_cnt++;
		end

	// Fixed latency unless a flush drops the request
	a_latency: assert property (@(posedge clk) disable iff (rst_i || flushpipe_i)
		$rose(req_i) |-> ##(fetch_bus_pkg::IMEM_WAIT) (ack_i || err_i))
		else begin
			$error("response not at fixed latency");
			fail_cnt++;
		end

	//////////////////////////////////////////////////
	// Stage outputs
	//////////////////////////////////////////////////

	a_forced_nop: assert property (@(posedge clk) disable iff (rst_i)
		(rfe_i || no_more_dslot_i) |-> (insn_i == isa_pkg::NOP_BYPASS))
		else begin
			$error("no bypass no-op during rfe or delay-slot end");
			fail_cnt++;
		end

	a_dslot_mask: assert property (@(posedge clk) disable iff (rst_i)
		no_more_dslot_i |-> (exc_i == 3'b000))
		else begin
			$error("exception raised at delay-slot end");
			fail_cnt++;
		end

endmodule

bind fetch_top fetch_props u_props (
	.clk             (clk),
	.rst_i           (rst_i),
	.flushpipe_i     (flushpipe_i),
	.no_more_dslot_i (no_more_dslot_i),
	.rfe_i           (rfe_i),
	.req_i           (bus_if.req),
	.ack_i           (bus_if.ack),
	.err_i           (bus_if.err),
	.insn_i          (insn_o),
	.exc_i           ({except_ibuserr_o, except_immufault_o, except_itlbmiss_o})
);

/* tb_fetch.sv */
// Fetch front end testbench
`timescale 1ns/10ps

module tb_fetch;

	localparam int DEPTH = fetch_bus_pkg::IMEM_DEPTH;
	localparam int FCYC  = fetch_bus_pkg::IMEM_WAIT + 3;
	// Test lengths in fetches
	localparam int LEN_RESET  = 1;
	localparam int LEN_SEQ    = 16;
	localparam int LEN_FREEZE = 12;
	localparam int LEN_FAULT  = 14;
	localparam int LEN_FLUSH  = 4;
	localparam int LEN_NOP    = 6;
	localparam int LEN_ALL    = LEN_RESET + LEN_SEQ + LEN_FREEZE + LEN_FAULT + LEN_FLUSH + LEN_NOP;
	localparam int SETUP_CYC  = DEPTH + 12;
	localparam int RESP_LIMIT = 4 * FCYC;
	localparam int WDOG_NS    = 20 * (SETUP_CYC + LEN_ALL * FCYC);

	logic clk, rst, load_hold;
	logic freeze, flushpipe, no_more_dslot, rfe, wr_en;
	fetch_bus_pkg::addr_t branch_target, wr_addr, pc, prev_pc, held_pc;
	isa_pkg::insn_t       wr_data, insn, held_insn;
	fetch_bus_pkg::tag_t  wr_tag;
	logic stall, saving, refetch, exc_tlb, exc_mmu, exc_bus;

	// Reference image of the memory
	isa_pkg::insn_t      ref_words [DEPTH];
	fetch_bus_pkg::tag_t ref_tags [DEPTH];
	integer seed;
	int errors, test_errs, checks, tests_run, tests_failed, cyc, props_fails;

	tb_clkgen u_clkgen (.hold_i(load_hold), .clk_o(clk), .rst_o(rst));

	fetch_top dut (
		.clk(clk), .rst_i(rst), .freeze_i(freeze), .flushpipe_i(flushpipe),
		.branch_target_i(branch_target), .no_more_dslot_i(no_more_dslot), .rfe_i(rfe),
		.wr_en_i(wr_en), .wr_addr_i(wr_addr), .wr_data_i(wr_data), .wr_tag_i(wr_tag),
		.insn_o(insn), .pc_o(pc), .stall_o(stall), .saving_insn_o(saving),
		.genpc_refetch_o(refetch), .except_itlbmiss_o(exc_tlb),
		.except_immufault_o(exc_mmu), .except_ibuserr_o(exc_bus)
	);

	// Word index of a byte address
	function automatic int ref_index(input fetch_bus_pkg::addr_t a);
		return int'((a >> 2) % DEPTH);
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("MISMATCH %s: got %h expected %h", name, got, exp);
			test_errs++;
		end
	endtask

	task automatic check_cond(input logic ok, input string what);
		checks++;
		if (ok !== 1'b1) begin
			$display("ERROR: %s", what);
			test_errs++;
		end
	endtask

	// Fetched word against the reference image
	task automatic check_fetch();
		check_val("insn_o", insn, ref_words[ref_index(pc)]);
	endtask

	// Step to the next negedge with a response
	task automatic wait_resp();
		int n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (stall && n < RESP_LIMIT);
		if (stall)
			check_cond(1'b0, "no fetch response in time");
	endtask

	// One flush, bypass no-op until the target is requested
	task automatic flush_to(input fetch_bus_pkg::addr_t target);
		flushpipe = 1'b1;
		branch_target = target;
		@(negedge clk);
		check_val("insn_o", insn, isa_pkg::NOP_BYPASS);
		flushpipe = 1'b0;
		@(negedge clk);
		// Target requested, bypass over, no answer yet
		check_val("insn_o", insn, isa_pkg::NOP_NOACK);
	endtask

	task automatic end_test(input string name);
		tests_run++;
		errors += test_errs;
		if (test_errs != 0) begin
			tests_failed++;
			$display("test %s: FAIL, %0d errors", name, test_errs);
		end else begin
			$display("test %s: ok", name);
		end
		test_errs = 0;
	endtask

	// Watchdog
	initial begin
		#(WDOG_NS);
		$display("Watchdog expired after %0d ns, run did not complete", WDOG_NS);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		seed = 10936;
		{freeze, flushpipe, no_more_dslot, rfe, wr_en} = '0;
		branch_target = '0;
		wr_addr = '0;
		wr_data = '0;
		wr_tag = fetch_bus_pkg::ITAG_NONE;
		load_hold = 1'b1;
		{errors, test_errs, checks, tests_run, tests_failed, cyc} = '0;
		for (int i = 0; i < DEPTH; i++) begin
			ref_words[i] = $random(seed);
			ref_tags[i] = fetch_bus_pkg::ITAG_NONE;
		end
		// Faulted words, two groups
		ref_tags[200] = fetch_bus_pkg::ITAG_TE;
		ref_tags[201] = fetch_bus_pkg::ITAG_PE;
		ref_tags[202] = fetch_bus_pkg::ITAG_BE;
		ref_tags[210] = fetch_bus_pkg::ITAG_TE;
		ref_tags[211] = fetch_bus_pkg::ITAG_PE;
		ref_tags[212] = fetch_bus_pkg::ITAG_BE;
		for (int i = 0; i < DEPTH; i++) begin
			@(negedge clk);
			wr_en = 1'b1;
			wr_addr = 32'(i * 4);
			wr_data = ref_words[i];
			wr_tag = ref_tags[i];
		end
		@(negedge clk);
		wr_en = 1'b0;
		load_hold = 1'b0;

		//////////////////////////////////////////////////
		// Reset up to first response
		//////////////////////////////////////////////////
		do begin
			@(negedge clk);
			cyc++;
			check_val("pc_o", pc, isa_pkg::RESET_VECTOR);
			check_val("exceptions", {29'b0, exc_bus, exc_mmu, exc_tlb}, 32'h0);
			if (rst)
				check_val("stall_o", stall, 1);
		end while (stall && cyc < SETUP_CYC);
		check_cond(!stall, "no first response after reset");
		end_test("reset");

		// Sequential fetch
		check_fetch();
		prev_pc = pc;
		repeat (LEN_SEQ - 1) begin
			wait_resp();
			check_val("pc_o", pc, prev_pc + 4);
			check_fetch();
			prev_pc = pc;
		end
		end_test("sequential");

		// Freeze while the next request is outstanding
		@(negedge clk);
		@(negedge clk);
		freeze = 1'b1;
		wait_resp();
		check_val("saving_insn_o", saving, 1);
		check_val("pc_o", pc, prev_pc + 4);
		check_fetch();
		held_pc = pc;
		held_insn = insn;
		repeat (8) begin
			@(negedge clk);
			check_val("saving_insn_o", saving, 0);
			check_val("insn_o", insn, held_insn);
			check_val("pc_o", pc, held_pc);
			check_val("stall_o", stall, 0);
			// No ack lands on the parked word
			check_val("genpc_refetch_o", refetch, 0);
		end
		freeze = 1'b0;
		wait_resp();
		check_val("pc_o", pc, held_pc + 4);
		check_fetch();
		end_test("freeze");

		//////////////////////////////////////////////////
		// Fault tags, then masked at delay-slot end
		//////////////////////////////////////////////////
		flush_to(32'(200 * 4));
		for (int k = 0; k < 3; k++) begin
			wait_resp();
			check_val("pc_o", pc, 32'((200 + k) * 4));
			check_val("exceptions", {29'b0, exc_bus, exc_mmu, exc_tlb}, 32'(1 << k));
			check_cond(insn !== ref_words[200 + k], "insn_o shows a faulted word");
		end
		flush_to(32'(210 * 4));
		no_more_dslot = 1'b1;
		repeat (3) begin
			wait_resp();
			check_val("exceptions", {29'b0, exc_bus, exc_mmu, exc_tlb}, 32'h0);
			check_val("insn_o", insn, isa_pkg::NOP_BYPASS);
		end
		no_more_dslot = 1'b0;
		end_test("fault_tags");

		// Flush to a clean region
		flush_to(32'h0000_0040);
		wait_resp();
		check_val("pc_o", pc, 32'h0000_0040);
		check_fetch();
		prev_pc = pc;
		end_test("flush_bypass");

		// Return from exception forces no-ops
		rfe = 1'b1;
		repeat (3) begin
			wait_resp();
			check_val("pc_o", pc, prev_pc + 4);
			check_val("insn_o", insn, isa_pkg::NOP_BYPASS);
			prev_pc = pc;
		end
		rfe = 1'b0;
		end_test("forced_nop");

		props_fails = int'(dut.u_props.fail_cnt);
		if (props_fails != 0) begin
			$display("ERROR: %0d assertion failures in fetch_props", props_fails);
			errors += props_fails;
		end
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

/* fetch_subsys.f */
isa_pkg.sv
fetch_bus_pkg.sv
fetch_bus_if.sv
fetch_genpc.sv
fetch_imem.sv
fetch_stage.sv
fetch_top.sv
tb_clkgen.sv
fetch_props.sv
tb_fetch.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fetch
FILELIST  ?= fetch_subsys.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
RUNARGS   ?= +verilator+error+limit+1000

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) $(RUNARGS) 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
